/* Makefile */
# Verilator build and run for the BDCR subsystem testbench

SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP      := bdcr_tb
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Simulation FAILED
PASS_MSG := Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with $(SIM), run it and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not complete"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD) $(LOG)

/* source/bdcr_bus_port.sv */
/*
 * Register-bus front end for the BDCR.
 * No back-pressure, a transfer is accepted in every cycle.
 * Writes reach the bank one cycle late, be[3] is ignored.
 * Read data is registered and flagged by a one-cycle rvalid.
 */
`timescale 1ns/10ps
`default_nettype none

module bdcr_bus_port (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        sel,
  input  wire logic        wr,
  input  wire logic [3:0]  addr,
  input  wire logic [3:0]  be,
  input  wire logic [31:0] wdata,
  output      logic [31:0] rdata,
  output      logic        rvalid,
  bdcr_wr_if.producer      bus
);

  logic addr_hit;
  logic wr_hit;
  logic rd_hit;

  // ----------------------------------------
  // decode
  // ----------------------------------------
  assign addr_hit = sel && (addr == bdcr_pkg::bdcr_addr);
  assign wr_hit   = addr_hit && wr;
  assign rd_hit   = addr_hit && !wr;

  // ----------------------------------------
  // write path
  // ----------------------------------------
  // strobes registered so the bank sees a clean one-cycle pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.byte_wren <= 3'b000;
    end else begin
      bus.byte_wren <= wr_hit ? be[2:0] : 3'b000;
    end
  end

  // write data held alongside the strobe
  // read-only and unused bits dropped here
  always_ff @(posedge clk) begin
    if (wr_hit) begin
      bus.wdata <= wdata & bdcr_pkg::bdcr_wr_mask;
    end
  end

  // ----------------------------------------
  // read path
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= rd_hit;
    end
  end

  // snapshot of the word at the read edge
  always_ff @(posedge clk) begin
    if (rd_hit) begin
      rdata <= bus.cur;
    end
  end

endmodule

`default_nettype wire

/* source/bdcr_pkg.sv */
/*
 * Shared constants for the backup-domain control register.
 * Field positions follow the 32-bit BDCR word layout.
 * Timing constants are in clk cycles or synchronized LSE edges.
 */
`default_nettype none

package bdcr_pkg;

  // register word address on the local bus
  localparam logic [3:0] bdcr_addr = 4'h0;

  // ----------------------------------------
  // field positions
  // ----------------------------------------
  localparam int bdrst_bit    = 16;
  localparam int rtcen_bit    = 15;
  localparam int rtcsel_lsb   = 8;
  localparam int lsecssd_bit  = 6;
  localparam int lsecsson_bit = 5;
  localparam int lsedrv_lsb   = 3;
  localparam int lsebyp_bit   = 2;
  localparam int lserdy_bit   = 1;
  localparam int lseon_bit    = 0;

  // bits that software can write, lsecssd and lserdy are status only
  localparam logic [31:0] bdcr_wr_mask = (32'h1 << bdrst_bit) | (32'h1 << rtcen_bit) |
                                         (32'h3 << rtcsel_lsb) | (32'h1 << lsecsson_bit) |
                                         (32'h3 << lsedrv_lsb) | (32'h1 << lsebyp_bit) |
                                         (32'h1 << lseon_bit);

  // ----------------------------------------
  // LSE monitor timing
  // ----------------------------------------
  localparam int lse_rdy_edges = 8;
  localparam int lse_byp_edges = 2;
  localparam int css_timeout   = 64;

  localparam int lse_cnt_w = $clog2(lse_rdy_edges + 1);
  localparam int css_cnt_w = $clog2(css_timeout);

  localparam logic [lse_cnt_w-1:0] rdy_cnt_full = lse_cnt_w'(lse_rdy_edges);
  localparam logic [lse_cnt_w-1:0] rdy_cnt_byp  = lse_cnt_w'(lse_byp_edges);
  localparam logic [css_cnt_w-1:0] css_cnt_last = css_cnt_w'(css_timeout - 1);

  // rtc clock source select
  typedef enum logic [1:0] {
    src_none = 2'd0,
    src_lse  = 2'd1,
    src_lsi  = 2'd2,
    src_hse  = 2'd3
  } rtc_src_e;

  // oscillator monitor states
  typedef enum logic [1:0] {
    lse_off      = 2'd0,
    lse_starting = 2'd1,
    lse_ready    = 2'd2,
    lse_failed   = 2'd3
  } lse_state_e;

endpackage

`default_nettype wire

/* source/bdcr_reg.sv */
/*
 * BDCR register bank, all fields synchronous to clk.
 * rtcsel is write-once and lsecsson set-once, both reopened by lsecss_fail.
 * lsecssd is sticky until rst. bdrst holds the other writable fields at 0.
 */
`timescale 1ns/10ps
`default_nettype none

module bdcr_reg (
  input  wire logic           clk,
  input  wire logic           rst,
  bdcr_wr_if.bank             bus,
  input  wire logic           lserdy,
  input  wire logic           lsecss_fail,
  output      logic           bdrst,
  output      logic           rtcen,
  output bdcr_pkg::rtc_src_e  rtcsel,
  output      logic           lsecsson,
  output      logic [1:0]     lsedrv,
  output      logic           lsebyp,
  output      logic           lseon
);

  logic               bdrst_nxt;
  logic               rtcsel_lock;
  logic               rtcsel_en;
  bdcr_pkg::rtc_src_e rtcsel_nxt;
  logic               lsecsson_en;
  logic               lsecssd;

  // ----------------------------------------
  // byte 2, backup domain reset
  // ----------------------------------------
  // next value, so the clear lands on the same edge as the bdrst write
  assign bdrst_nxt = bus.byte_wren[2] ? bus.wdata[bdcr_pkg::bdrst_bit] : bdrst;

  always_ff @(posedge clk) begin
    if (rst) begin
      bdrst <= 1'b0;
    end else if (bus.byte_wren[2]) begin
      bdrst <= bus.wdata[bdcr_pkg::bdrst_bit];
    end
  end

  // ----------------------------------------
  // byte 1, rtcen and rtcsel
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst || bdrst_nxt) begin
      rtcen <= 1'b0;
    end else if (bus.byte_wren[1]) begin
      rtcen <= bus.wdata[bdcr_pkg::rtcen_bit];
    end
  end

  // open while unlocked, or in the css failure cycle
  assign rtcsel_en  = bus.byte_wren[1] && (!rtcsel_lock || lsecss_fail);
  assign rtcsel_nxt = rtcsel_en ?
                      bdcr_pkg::rtc_src_e'(bus.wdata[bdcr_pkg::rtcsel_lsb +: 2]) : rtcsel;

  always_ff @(posedge clk) begin
    if (rst || bdrst_nxt) begin
      rtcsel      <= bdcr_pkg::src_none;
      rtcsel_lock <= 1'b0;
    end else begin
      rtcsel <= rtcsel_nxt;
      // lock once a source is chosen
      if (bus.byte_wren[1] && (rtcsel_nxt != bdcr_pkg::src_none)) begin
        rtcsel_lock <= 1'b1;
      end else if (lsecss_fail) begin
        rtcsel_lock <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // byte 0, css control and status
  // ----------------------------------------
  // sticky failure flag, only rst clears it
  always_ff @(posedge clk) begin
    if (rst) begin
      lsecssd <= 1'b0;
    end else if (lsecss_fail) begin
      lsecssd <= 1'b1;
    end
  end

  // set-once, the bit is its own lock
  assign lsecsson_en = bus.byte_wren[0] && (!lsecsson || lsecss_fail);

  always_ff @(posedge clk) begin
    if (rst || bdrst_nxt) begin
      lsecsson <= 1'b0;
    end else if (lsecsson_en) begin
      lsecsson <= bus.wdata[bdcr_pkg::lsecsson_bit];
    end else if (lsecss_fail) begin
      lsecsson <= 1'b0;
    end
  end

  // ----------------------------------------
  // byte 0, plain oscillator controls
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst || bdrst_nxt) begin
      lsedrv <= 2'b00;
      lsebyp <= 1'b0;
      lseon  <= 1'b0;
    end else if (bus.byte_wren[0]) begin
      lsedrv <= bus.wdata[bdcr_pkg::lsedrv_lsb +: 2];
      lsebyp <= bus.wdata[bdcr_pkg::lsebyp_bit];
      lseon  <= bus.wdata[bdcr_pkg::lseon_bit];
    end
  end

  // ----------------------------------------
  // readback word
  // ----------------------------------------
  always_comb begin
    bus.cur                                    = 32'h0;
    bus.cur[bdcr_pkg::bdrst_bit]               = bdrst;
    bus.cur[bdcr_pkg::rtcen_bit]               = rtcen;
    bus.cur[bdcr_pkg::rtcsel_lsb +: 2]         = rtcsel;
    bus.cur[bdcr_pkg::lsecssd_bit]             = lsecssd;
    bus.cur[bdcr_pkg::lsecsson_bit]            = lsecsson;
    bus.cur[bdcr_pkg::lsedrv_lsb +: 2]         = lsedrv;
    bus.cur[bdcr_pkg::lsebyp_bit]              = lsebyp;
    bus.cur[bdcr_pkg::lserdy_bit]              = lserdy;  // live status from the monitor
    bus.cur[bdcr_pkg::lseon_bit]               = lseon;
  end

endmodule

`default_nettype wire

/* source/bdcr_top.sv */
/*
 * BDCR subsystem top, bus port plus register bank plus LSE monitor.
 * lse_clk is asynchronous, everything else runs on clk.
 * Field outputs change two edges after a bus write.
 */
`timescale 1ns/10ps
`default_nettype none

module bdcr_top (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          sel,
  input  wire logic          wr,
  input  wire logic [3:0]    addr,
  input  wire logic [3:0]    be,
  input  wire logic [31:0]   wdata,
  input  wire logic          lse_clk,
  output      logic [31:0]   rdata,
  output      logic          rvalid,
  output      logic          bdrst,
  output      logic          lseon,
  output      logic          lsebyp,
  output      logic [1:0]    lsedrv,
  output bdcr_pkg::rtc_src_e rtc_src,
  output      logic          rtc_clk_en
);

  // ----------------------------------------
  // internal links
  // ----------------------------------------
  logic rtcen;
  logic lsecsson;
  logic lserdy;
  logic lsecss_fail;

  bdcr_wr_if wr_if ();

  bdcr_bus_port u_bus_port (
    .clk    (clk),
    .rst    (rst),
    .sel    (sel),
    .wr     (wr),
    .addr   (addr),
    .be     (be),
    .wdata  (wdata),
    .rdata  (rdata),
    .rvalid (rvalid),
    .bus    (wr_if.producer)
  );

  bdcr_reg u_reg (
    .clk         (clk),
    .rst         (rst),
    .bus         (wr_if.bank),
    .lserdy      (lserdy),
    .lsecss_fail (lsecss_fail),
    .bdrst       (bdrst),
    .rtcen       (rtcen),
    .rtcsel      (rtc_src),
    .lsecsson    (lsecsson),
    .lsedrv      (lsedrv),
    .lsebyp      (lsebyp),
    .lseon       (lseon)
  );

  // monitor sees the live field values
  lse_css_monitor u_monitor (
    .clk         (clk),
    .rst         (rst),
    .lse_clk     (lse_clk),
    .lseon       (lseon),
    .lsebyp      (lsebyp),
    .lsecsson    (lsecsson),
    .rtcen       (rtcen),
    .rtcsel      (rtc_src),
    .lserdy      (lserdy),
    .lsecss_fail (lsecss_fail),
    .rtc_clk_en  (rtc_clk_en)
  );

endmodule

`default_nettype wire

/* source/bdcr_wr_if.sv */
/*
 * Write path between the bus port and the BDCR bank.
 * byte_wren bits are one-cycle strobes, wdata is valid with them.
 * cur returns the full register word for readback.
 */
`timescale 1ns/10ps
`default_nettype none

interface bdcr_wr_if;

  logic [2:0]  byte_wren;  // one strobe per byte 0..2
  logic [31:0] wdata;
  logic [31:0] cur;        // live register value

  // bus side
  modport producer (
    output byte_wren,
    output wdata,
    input  cur
  );

  // register bank side
  modport bank (
    input  byte_wren,
    input  wdata,
    output cur
  );

endinterface

`default_nettype wire

/* source/lse_css_monitor.sv */
/*
 * LSE ready detection and clock security watchdog.
 * lse_clk is asynchronous and must be much slower than clk.
 * Only rising edges after a two-flop synchronizer are counted.
 * A failure is latched until lseon is cleared.
 */
`timescale 1ns/10ps
`default_nettype none

module lse_css_monitor (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          lse_clk,
  input  wire logic          lseon,
  input  wire logic          lsebyp,
  input  wire logic          lsecsson,
  input  wire logic          rtcen,
  input  wire bdcr_pkg::rtc_src_e rtcsel,
  output      logic          lserdy,
  output      logic          lsecss_fail,
  output      logic          rtc_clk_en
);

  logic                              lse_meta;
  logic                              lse_sync;
  logic                              lse_prev;
  logic                              lse_edge;
  bdcr_pkg::lse_state_e              state;
  logic [bdcr_pkg::lse_cnt_w-1:0]    edge_cnt;
  logic [bdcr_pkg::css_cnt_w-1:0]    wd_cnt;
  logic [bdcr_pkg::lse_cnt_w-1:0]    rdy_target;
  logic                              wd_expired;

  // ----------------------------------------
  // synchronizer and edge detect
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      lse_meta <= 1'b0;
      lse_sync <= 1'b0;
      lse_prev <= 1'b0;
    end else begin
      lse_meta <= lse_clk;
      lse_sync <= lse_meta;
      lse_prev <= lse_sync;
    end
  end

  assign lse_edge = lse_sync && !lse_prev;

  // bypass clock is already clean, fewer edges needed
  assign rdy_target = lsebyp ? bdcr_pkg::rdy_cnt_byp : bdcr_pkg::rdy_cnt_full;
  assign wd_expired = !lse_edge && (wd_cnt == bdcr_pkg::css_cnt_last);

  // ----------------------------------------
  // monitor FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= bdcr_pkg::lse_off;
      edge_cnt    <= '0;
      wd_cnt      <= '0;
      lsecss_fail <= 1'b0;
    end else begin
      lsecss_fail <= 1'b0;
      if (!lseon) begin
        state    <= bdcr_pkg::lse_off;
        edge_cnt <= '0;
        wd_cnt   <= '0;
      end else begin
        case (state)
          bdcr_pkg::lse_off: begin
            state    <= bdcr_pkg::lse_starting;
            edge_cnt <= '0;
          end
          bdcr_pkg::lse_starting: begin
            if (lse_edge) begin
              if (edge_cnt + 1'b1 >= rdy_target) begin
                state  <= bdcr_pkg::lse_ready;
                wd_cnt <= '0;
              end else begin
                edge_cnt <= edge_cnt + 1'b1;
              end
            end
          end
          bdcr_pkg::lse_ready: begin
            // watchdog reloads on every edge
            if (lse_edge) begin
              wd_cnt <= '0;
            end else if (wd_expired) begin
              edge_cnt <= '0;
              wd_cnt   <= '0;
              if (lsecsson) begin
                state       <= bdcr_pkg::lse_failed;
                lsecss_fail <= 1'b1;  // single pulse on entry
              end else begin
                state <= bdcr_pkg::lse_starting;  // no css, just restart
              end
            end else begin
              wd_cnt <= wd_cnt + 1'b1;
            end
          end
          default: begin
            // failed holds until lseon drops
            state <= bdcr_pkg::lse_failed;
          end
        endcase
      end
    end
  end

  assign lserdy = (state == bdcr_pkg::lse_ready);

  // gate only applies when lse feeds the rtc
  assign rtc_clk_en = rtcen && ((rtcsel != bdcr_pkg::src_lse) || lserdy);

endmodule

`default_nettype wire

/* test/bdcr_sva.sv */
/*
 * Concurrent checks on the BDCR bank field rules.
 * Bound into every bdcr_reg instance, needs assertions enabled.
 */
`timescale 1ns/10ps
`default_nettype none

module bdcr_sva (
  input wire logic       clk,
  input wire logic       rst,
  input wire logic       lsecssd,
  input wire logic       lsecsson,
  input wire logic       lsecss_fail,
  input wire logic       bdrst,
  input wire logic [1:0] rtcsel,
  input wire logic       rtcsel_lock
);

  // ----------------------------------------
  // css flags
  // ----------------------------------------
  // failure flag is sticky, only rst clears it
  a_cssd_sticky: assert property (
    @(posedge clk) disable iff (rst)
    $fell(lsecssd) |-> $past(rst)
  ) else $error("lsecssd cleared without rst");

  // set-once enable, bdrst lands on the same edge as the clear
  a_csson_hold: assert property (
    @(posedge clk) disable iff (rst)
    $fell(lsecsson) |-> ($past(lsecss_fail) || bdrst)
  ) else $error("lsecsson cleared without css failure or bdrst");

  // ----------------------------------------
  // rtc source lock
  // ----------------------------------------
  // locked source only moves in the failure cycle or under bdrst
  a_rtcsel_locked: assert property (
    @(posedge clk) disable iff (rst)
    ($past(rtcsel_lock && !lsecss_fail) && !bdrst) |-> $stable(rtcsel)
  ) else $error("rtcsel changed while locked");

endmodule

bind bdcr_reg bdcr_sva u_sva (
  .clk         (clk),
  .rst         (rst),
  .lsecssd     (lsecssd),
  .lsecsson    (lsecsson),
  .lsecss_fail (lsecss_fail),
  .bdrst       (bdrst),
  .rtcsel      (rtcsel),
  .rtcsel_lock (rtcsel_lock)
);

`default_nettype wire

/* test/bdcr_tb.sv */
/*
 * Table-driven testbench for the BDCR subsystem.
 * lse_clk is modeled as a 40 ns clock gated by lse_run.
 * Each row is one bus operation, output check or register poll.
 */
`timescale 1ns/10ps
`default_nettype none

module bdcr_tb;

  // row operations and lse actions
  localparam int op_rd   = 0;
  localparam int op_wr   = 1;
  localparam int op_rnd  = 2;
  localparam int op_wait = 3;
  localparam int op_out  = 4;
  localparam int lse_keep  = 0;
  localparam int lse_start = 1;
  localparam int lse_stop  = 2;

  localparam int rd_limit     = 8;
  localparam int poll_limit   = bdcr_pkg::css_timeout + 32;
  localparam int run_limit_ns = 200000;

  // register field masks
  localparam logic [31:0] m_all      = 32'hffff_ffff;
  localparam logic [31:0] m_bdrst    = 32'h1 << bdcr_pkg::bdrst_bit;
  localparam logic [31:0] m_rtcen    = 32'h1 << bdcr_pkg::rtcen_bit;
  localparam logic [31:0] m_rtcsel   = 32'h3 << bdcr_pkg::rtcsel_lsb;
  localparam logic [31:0] m_lsecssd  = 32'h1 << bdcr_pkg::lsecssd_bit;
  localparam logic [31:0] m_lsecsson = 32'h1 << bdcr_pkg::lsecsson_bit;
  localparam logic [31:0] m_lsedrv   = 32'h3 << bdcr_pkg::lsedrv_lsb;
  localparam logic [31:0] m_lsebyp   = 32'h1 << bdcr_pkg::lsebyp_bit;
  localparam logic [31:0] m_lserdy   = 32'h1 << bdcr_pkg::lserdy_bit;
  localparam logic [31:0] m_lseon    = 32'h1 << bdcr_pkg::lseon_bit;
  localparam logic [31:0] m_plain    = m_rtcen | m_lsedrv | m_lsebyp | m_lseon;
  localparam logic [31:0] v_src_lse  = 32'(bdcr_pkg::src_lse) << bdcr_pkg::rtcsel_lsb;
  localparam logic [31:0] v_src_lsi  = 32'(bdcr_pkg::src_lsi) << bdcr_pkg::rtcsel_lsb;
  localparam logic [31:0] v_src_hse  = 32'(bdcr_pkg::src_hse) << bdcr_pkg::rtcsel_lsb;

  // top output vector, bdrst at bit 7 down to lseon at bit 0
  localparam logic [31:0] o_all     = 32'hff;
  localparam logic [31:0] o_bdrst   = 32'h80;
  localparam logic [31:0] o_clk_en  = 32'h40;
  localparam logic [31:0] o_src     = 32'h30;
  localparam logic [31:0] o_src_lse = 32'(bdcr_pkg::src_lse) << 4;
  localparam logic [31:0] o_src_lsi = 32'(bdcr_pkg::src_lsi) << 4;

  logic               clk     = 1'b0;
  logic               rst     = 1'b1;
  logic               sel     = 1'b0;
  logic               wr      = 1'b0;
  logic [3:0]         addr    = 4'h0;
  logic [3:0]         be      = 4'h0;
  logic [31:0]        wdata   = 32'h0;
  logic               lse_clk = 1'b0;
  logic               lse_run = 1'b0;
  logic [31:0]        rdata;
  logic               rvalid;
  logic               bdrst;
  logic               lseon;
  logic               lsebyp;
  logic [1:0]         lsedrv;
  bdcr_pkg::rtc_src_e rtc_src;
  logic               rtc_clk_en;
  logic [31:0]        outs;

  // stimulus table, one entry per row
  int          tid_q[$];
  int          op_q[$];
  logic [3:0]  be_q[$];
  logic [31:0] data_q[$];
  logic [31:0] mask_q[$];
  logic [31:0] exp_q[$];
  int          lse_q[$];

  int          errors    = 0;
  int          checks    = 0;
  int          test_err  = 0;
  logic [31:0] rng       = 32'h808ba359;
  logic [31:0] plain_exp = 32'h0;

  bdcr_top DUT (
    .clk        (clk),
    .rst        (rst),
    .sel        (sel),
    .wr         (wr),
    .addr       (addr),
    .be         (be),
    .wdata      (wdata),
    .lse_clk    (lse_clk),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .bdrst      (bdrst),
    .lseon      (lseon),
    .lsebyp     (lsebyp),
    .lsedrv     (lsedrv),
    .rtc_src    (rtc_src),
    .rtc_clk_en (rtc_clk_en)
  );

  assign outs = {24'h0, bdrst, rtc_clk_en, rtc_src, lsedrv, lsebyp, lseon};

  always #5 clk = ~clk;

  // lse toggles on clk falling edges, free of races with the bus
  always begin
    #20;
    if (lse_run) begin
      lse_clk = ~lse_clk;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // be[3] has no byte behind it
  function automatic logic [31:0] byte_mask(input logic [3:0] b);
    return {8'h00, {8{b[2]}}, {8{b[1]}}, {8{b[0]}}};
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "reset and rw fields";
      2: return "rtcsel write-once";
      3: return "lsecsson set-once";
      4: return "lse ready and rtc_clk_en";
      5: return "css failure";
      default: return "bdrst";
    endcase
  endfunction

  task automatic note_error();
    errors   = errors + 1;
    test_err = test_err + 1;
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks = checks + 1;
    if (got !== exp) begin
      $display("[ERROR] t=%0d ns: %s, got %h expected %h", $time, what, got, exp);
      note_error();
    end
  endtask

  task automatic add_row(input int t, input int op, input logic [3:0] b, input logic [31:0] d,
                         input logic [31:0] m, input logic [31:0] e, input int lse);
    tid_q.push_back(t);
    op_q.push_back(op);
    be_q.push_back(b);
    data_q.push_back(d);
    mask_q.push_back(m);
    exp_q.push_back(e);
    lse_q.push_back(lse);
  endtask

  // ----------------------------------------
  // bus tasks
  // ----------------------------------------
  task automatic bus_write(input logic [3:0] b, input logic [31:0] d);
    @(posedge clk);
    sel   <= 1'b1;
    wr    <= 1'b1;
    addr  <= bdcr_pkg::bdcr_addr;
    be    <= b;
    wdata <= d;
    @(posedge clk);
    sel <= 1'b0;
    wr  <= 1'b0;
    // idle cycle while the bank takes the strobe
    @(posedge clk);
  endtask

  task automatic bus_read(output logic [31:0] d, output logic ok);
    int n;
    @(posedge clk);
    sel  <= 1'b1;
    wr   <= 1'b0;
    addr <= bdcr_pkg::bdcr_addr;
    be   <= 4'h0;
    @(posedge clk);
    sel <= 1'b0;
    ok = 1'b0;
    d  = 32'h0;
    for (n = 0; n < rd_limit && !ok; n++) begin
      @(negedge clk);
      if (rvalid) begin
        ok = 1'b1;
        d  = rdata;
      end
    end
    if (!ok) begin
      $display("timeout: no read response from the DUT within %0d cycles", rd_limit);
      note_error();
    end
  endtask

  // repeated reads until the masked field matches
  task automatic poll_until(input logic [31:0] m, input logic [31:0] e);
    int          n;
    logic [31:0] d;
    logic        ok;
    logic        hit;
    hit = 1'b0;
    for (n = 0; n < poll_limit && !hit; n++) begin
      bus_read(d, ok);
      hit = ok && ((d & m) == e);
    end
    checks = checks + 1;
    if (!hit) begin
      $display("timeout: field %h never read as %h within %0d reads", m, e, poll_limit);
      note_error();
    end
  endtask

  // random write of the plain rw fields, then readback and outputs
  task automatic rand_rw_step(input logic [3:0] b);
    logic [31:0] d;
    logic [31:0] got;
    logic        ok;
    rng = xorshift(rng);
    d   = rng & m_plain;
    bus_write(b, d);
    plain_exp = (plain_exp & ~byte_mask(b)) | (d & byte_mask(b));
    bus_read(got, ok);
    if (ok) begin
      check(got & m_plain, plain_exp, "rw field readback");
    end
    // rtcsel is src_none here, so rtc_clk_en follows rtcen
    check(outs, {24'h0, 1'b0, plain_exp[bdcr_pkg::rtcen_bit], 2'b00,
                 plain_exp[bdcr_pkg::lsedrv_lsb +: 2], plain_exp[bdcr_pkg::lsebyp_bit],
                 plain_exp[bdcr_pkg::lseon_bit]}, "rw field outputs");
  endtask

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  task automatic build_table();
    add_row(1, op_rd,   4'h0, 32'h0, m_all, 32'h0, lse_keep);
    add_row(1, op_rnd,  4'h7, 32'h0, 32'h0, 32'h0, lse_keep);
    add_row(1, op_rnd,  4'h7, 32'h0, 32'h0, 32'h0, lse_keep);
    add_row(1, op_rnd,  4'h7, 32'h0, 32'h0, 32'h0, lse_keep);
    add_row(1, op_rnd,  4'h1, 32'h0, 32'h0, 32'h0, lse_keep);
    add_row(1, op_rnd,  4'h2, 32'h0, 32'h0, 32'h0, lse_keep);
    add_row(1, op_rnd,  4'h8, 32'h0, 32'h0, 32'h0, lse_keep);
    add_row(1, op_wr,   4'h7, 32'h0, 32'h0, 32'h0, lse_keep);
    add_row(1, op_rd,   4'h0, 32'h0, m_all, 32'h0, lse_keep);
    add_row(2, op_wr,   4'h2, v_src_lse, 32'h0, 32'h0, lse_keep);
    add_row(2, op_wr,   4'h2, v_src_hse, 32'h0, 32'h0, lse_keep);
    add_row(2, op_rd,   4'h0, 32'h0, m_rtcsel, v_src_lse, lse_keep);
    add_row(2, op_out,  4'h0, 32'h0, o_src, o_src_lse, lse_keep);
    add_row(3, op_wr,   4'h1, m_lsecsson, 32'h0, 32'h0, lse_keep);
    add_row(3, op_wr,   4'h1, 32'h0, 32'h0, 32'h0, lse_keep);
    add_row(3, op_rd,   4'h0, 32'h0, m_lsecsson, m_lsecsson, lse_keep);
    add_row(4, op_wr,   4'h1, m_lseon | m_lsecsson, 32'h0, 32'h0, lse_start);
    add_row(4, op_wait, 4'h0, 32'h0, m_lserdy, m_lserdy, lse_keep);
    add_row(4, op_wr,   4'h2, m_rtcen | v_src_lse, 32'h0, 32'h0, lse_keep);
    add_row(4, op_out,  4'h0, 32'h0, o_clk_en, o_clk_en, lse_keep);
    add_row(4, op_rd,   4'h0, 32'h0, m_rtcen | m_rtcsel, m_rtcen | v_src_lse, lse_keep);
    add_row(5, op_wait, 4'h0, 32'h0, m_lsecssd, m_lsecssd, lse_stop);
    add_row(5, op_rd,   4'h0, 32'h0, m_lserdy | m_lsecsson, 32'h0, lse_keep);
    add_row(5, op_wr,   4'h2, m_rtcen | v_src_lsi, 32'h0, 32'h0, lse_keep);
    add_row(5, op_rd,   4'h0, 32'h0, m_rtcsel, v_src_lsi, lse_keep);
    add_row(5, op_out,  4'h0, 32'h0, o_src, o_src_lsi, lse_keep);
    // lsecsson set again so bdrst has a locked bit to clear
    add_row(6, op_wr,   4'h1, m_lseon | m_lsecsson, 32'h0, 32'h0, lse_keep);
    add_row(6, op_rd,   4'h0, 32'h0, m_lsecsson, m_lsecsson, lse_keep);
    add_row(6, op_wr,   4'h4, m_bdrst, 32'h0, 32'h0, lse_keep);
    add_row(6, op_rd,   4'h0, 32'h0, m_all, m_bdrst | m_lsecssd, lse_keep);
    add_row(6, op_out,  4'h0, 32'h0, o_all, o_bdrst, lse_keep);
    add_row(6, op_wr,   4'h4, 32'h0, 32'h0, 32'h0, lse_keep);
    add_row(6, op_wr,   4'h1, m_lsecsson, 32'h0, 32'h0, lse_keep);
    add_row(6, op_rd,   4'h0, 32'h0, m_bdrst | m_lsecsson | m_lsecssd,
            m_lsecsson | m_lsecssd, lse_keep);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : main
    int          i;
    logic [31:0] got;
    logic        ok;
    build_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (i = 0; i < op_q.size(); i++) begin
      if (lse_q[i] == lse_start) begin
        lse_run = 1'b1;
      end else if (lse_q[i] == lse_stop) begin
        lse_run = 1'b0;
      end
      case (op_q[i])
        op_wr: bus_write(be_q[i], data_q[i]);
        op_rnd: rand_rw_step(be_q[i]);
        op_wait: poll_until(mask_q[i], exp_q[i]);
        op_rd: begin
          bus_read(got, ok);
          if (ok) begin
            check(got & mask_q[i], exp_q[i], $sformatf("readback row %0d", i));
          end
        end
        default: begin
          @(negedge clk);
          check(outs & mask_q[i], exp_q[i], $sformatf("top outputs row %0d", i));
        end
      endcase
      // last row of a test closes it
      if (i == op_q.size() - 1 || tid_q[i + 1] != tid_q[i]) begin
        $display("test %0d (%s): %s, %0d errors", tid_q[i], test_name(tid_q[i]),
                 (test_err == 0) ? "ok" : "failed", test_err);
        test_err = 0;
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // run limit in case a wait loop misbehaves
  initial begin
    #(run_limit_ns);
    $display("run stopped after %0d ns, the test sequence did not finish", run_limit_ns);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
source/bdcr_pkg.sv
source/bdcr_wr_if.sv
source/bdcr_bus_port.sv
source/bdcr_reg.sv
source/lse_css_monitor.sv
source/bdcr_top.sv
test/bdcr_sva.sv
test/bdcr_tb.sv
